/* source/datapathPkg.sv */
package datapathPkg;

        localparam int dataWidth = 32;
        localparam int regCount = 16;
        localparam int sourceCodeWidth = 5;
        localparam int divideSteps = 32;
        localparam int immediateWidth = 19;

        typedef enum logic [4:0] {
                opAdd = 5'd3,
                opSub = 5'd4,
                opShr = 5'd5,
                opShl = 5'd6,
                opAnd = 5'd9,
                opOr  = 5'd10,
                opMul = 5'd14,
                opDiv = 5'd15,
                opNeg = 5'd16,
                opNot = 5'd17
        } aluOpT;

        // msb first, so a strobe's bit position equals its source code.
        typedef struct packed {
                logic c;
                logic mdr;
                logic pc;
                logic zLow;
                logic zHigh;
                logic lo;
                logic hi;
                logic [regCount-1:0] gpr;
        } busSourcesT;

        typedef struct packed {
                logic mdr;
                logic mar;
                logic lo;
                logic hi;
                logic z;
                logic y;
                logic ir;
                logic pc;
                logic [regCount-1:0] gpr;
        } loadEnablesT;

        typedef logic [sourceCodeWidth-1:0] sourceCodeT;

        localparam sourceCodeT codeHi = 5'd16;
        localparam sourceCodeT codeLo = 5'd17;
        localparam sourceCodeT codeZHigh = 5'd18;
        localparam sourceCodeT codeZLow = 5'd19;
        localparam sourceCodeT codePc = 5'd20;
        localparam sourceCodeT codeMdr = 5'd21;
        localparam sourceCodeT codeC = 5'd22;
        localparam sourceCodeT codeNone = 5'd31;

endpackage

/* source/busEncoder.sv */
`timescale 1ns/1ns

module busEncoder import datapathPkg::*; (
        input  busSourcesT               sources,
        input  logic [dataWidth-1:0]     regValue,
        input  logic [dataWidth-1:0]     mdrValue,
        input  logic [dataWidth-1:0]     hiValue,
        input  logic [dataWidth-1:0]     loValue,
        input  logic [dataWidth-1:0]     zHighValue,
        input  logic [dataWidth-1:0]     zLowValue,
        input  logic [dataWidth-1:0]     pcValue,
        input  logic [dataWidth-1:0]     cValue,
        output sourceCodeT               sourceCode,
        output logic [dataWidth-1:0]     busData
);

        logic [$bits(busSourcesT)-1:0] sourceBits;

        assign sourceBits = sources;

        // or of the indices of all raised strobes, valid for one-hot input.
        always_comb begin
                sourceCode = '0;
                for (int i = 0; i < $bits(busSourcesT); i++) begin
                        if (sourceBits[i])
                                sourceCode = sourceCode | sourceCodeT'(i);
                end
                if (sourceBits == '0)
                        sourceCode = codeNone;
        end

        always_comb begin
                if (sourceCode < regCount) begin
                        busData = regValue;
                end else begin
                        case (sourceCode)
                                codeHi:    busData = hiValue;
                                codeLo:    busData = loValue;
                                codeZHigh: busData = zHighValue;
                                codeZLow:  busData = zLowValue;
                                codePc:    busData = pcValue;
                                codeMdr:   busData = mdrValue;
                                codeC:     busData = cValue;
                                default:   busData = '0;
                        endcase
                end
        end

        // two drivers at once would corrupt the encoded index.
        always_comb begin
                assert final ($onehot0(sourceBits))
                else $error("more than one bus source enabled: %h", sourceBits);
        end

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ns

module registerFile import datapathPkg::*; (
        input  logic                    Clock,
        input  logic                    rstN,
        input  logic [regCount-1:0]     loads,
        input  sourceCodeT              sourceCode,
        input  logic [dataWidth-1:0]    busData,
        output logic [dataWidth-1:0]    regValue
);

        localparam int indexWidth = $clog2(regCount);

        logic [dataWidth-1:0] generalRegs [regCount];

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < regCount; i++)
                                generalRegs[i] <= '0;
                end else begin
                        for (int i = 0; i < regCount; i++) begin
                                if (loads[i])
                                        generalRegs[i] <= busData;
                        end
                end
        end

        // codes above the register range read as zero.
        assign regValue = (sourceCode < regCount) ?
                          generalRegs[sourceCode[indexWidth-1:0]] : '0;

        assert property (@(posedge Clock) disable iff (!rstN) $onehot0(loads))
        else $error("several general registers loaded at once: %h", loads);

endmodule

/* source/memoryDataRegister.sv */
`timescale 1ns/1ns

module memoryDataRegister import datapathPkg::*; (
        input  logic                    Clock,
        input  logic                    rstN,
        input  logic                    mdrLoad,
        input  logic                    marLoad,
        input  logic                    read,
        input  logic [dataWidth-1:0]    memData,
        input  logic [dataWidth-1:0]    busData,
        output logic [dataWidth-1:0]    mdrValue,
        output logic [dataWidth-1:0]    marValue
);

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        mdrValue <= '0;
                        marValue <= '0;
                end else begin
                        // read picks memory, otherwise the bus.
                        if (mdrLoad)
                                mdrValue <= read ? memData : busData;
                        if (marLoad)
                                marValue <= busData;
                end
        end

endmodule

/* source/specialRegisters.sv */
`timescale 1ns/1ns

module specialRegisters import datapathPkg::*; (
        input  logic                      Clock,
        input  logic                      rstN,
        input  loadEnablesT               loads,
        input  logic                      incPc,
        input  logic [dataWidth-1:0]      busData,
        input  logic [2*dataWidth-1:0]    zResult,
        input  logic                      zWrite,
        output logic [dataWidth-1:0]      pcValue,
        output logic [dataWidth-1:0]      irValue,
        output logic [dataWidth-1:0]      yValue,
        output logic [dataWidth-1:0]      hiValue,
        output logic [dataWidth-1:0]      loValue,
        output logic [dataWidth-1:0]      zHighValue,
        output logic [dataWidth-1:0]      zLowValue,
        output logic [dataWidth-1:0]      cValue
);

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        pcValue    <= '0;
                        irValue    <= '0;
                        yValue     <= '0;
                        hiValue    <= '0;
                        loValue    <= '0;
                        zHighValue <= '0;
                        zLowValue  <= '0;
                end else begin
                        // a bus load wins over the increment.
                        if (loads.pc)
                                pcValue <= busData;
                        else if (incPc)
                                pcValue <= pcValue + 1'b1;
                        if (loads.ir)
                                irValue <= busData;
                        if (loads.y)
                                yValue <= busData;
                        if (loads.hi)
                                hiValue <= busData;
                        if (loads.lo)
                                loValue <= busData;
                        if (zWrite) begin
                                zHighValue <= zResult[2*dataWidth-1:dataWidth];
                                zLowValue  <= zResult[dataWidth-1:0];
                        end
                end
        end

        // sign-extended immediate field of IR.
        assign cValue = {{(dataWidth-immediateWidth){irValue[immediateWidth-1]}},
                         irValue[immediateWidth-1:0]};

        assert property (@(posedge Clock) disable iff (!rstN) !(loads.pc && incPc))
        else $error("pc load and pc increment raised together");

endmodule

/* source/divider.sv */
`timescale 1ns/1ns

module divider import datapathPkg::*; (
        input  logic                    Clock,
        input  logic                    rstN,
        input  logic                    start,
        input  logic [dataWidth-1:0]    dividend,
        input  logic [dataWidth-1:0]    divisor,
        output logic                    busy,
        output logic                    done,
        output logic [dataWidth-1:0]    quotient,
        output logic [dataWidth-1:0]    remainder
);

        localparam int countWidth = $clog2(divideSteps);

        logic [countWidth-1:0] stepCount;
        logic [dataWidth-1:0]  remainderReg;
        logic [dataWidth-1:0]  quotientReg;
        logic [dataWidth-1:0]  divisorReg;
        logic [dataWidth:0]    partial;
        logic [dataWidth+1:0]  trial;
        logic                  stepFits;

        // one restoring step, shared by the registers and the outputs.
        assign partial   = {remainderReg, quotientReg[dataWidth-1]};
        assign trial     = {1'b0, partial} - {2'b00, divisorReg};
        assign stepFits  = !trial[dataWidth+1];
        assign remainder = stepFits ? trial[dataWidth-1:0] : partial[dataWidth-1:0];
        assign quotient  = {quotientReg[dataWidth-2:0], stepFits};

        // outputs carry the final step while done is high.
        assign done = busy && (stepCount == divideSteps - 1);

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        busy      <= 1'b0;
                        stepCount <= '0;
                end else if (start && !busy) begin
                        busy      <= 1'b1;
                        stepCount <= '0;
                end else if (busy) begin
                        stepCount <= stepCount + 1'b1;
                        if (done)
                                busy <= 1'b0;
                end
        end

        // zero divisor: every trial fits, so quotient ends all ones and
        // the dividend shifts whole into the remainder.
        always_ff @(posedge Clock) begin
                if (start && !busy) begin
                        remainderReg <= '0;
                        quotientReg  <= dividend;
                        divisorReg   <= divisor;
                end else if (busy) begin
                        remainderReg <= remainder;
                        quotientReg  <= quotient;
                end
        end

        assert property (@(posedge Clock) disable iff (!rstN) busy |-> !start)
        else $error("divide started while busy");

endmodule

/* source/alu.sv */
`timescale 1ns/1ns

module alu import datapathPkg::*; (
        input  logic                      Clock,
        input  logic                      rstN,
        input  aluOpT                     op,
        input  logic                      zLoad,
        input  logic [dataWidth-1:0]      yValue,
        input  logic [dataWidth-1:0]      busData,
        output logic [2*dataWidth-1:0]    zResult,
        output logic                      zWrite,
        output logic                      busy
);

        localparam int shiftWidth = $clog2(dataWidth);

        logic [2*dataWidth-1:0] opResult;
        logic [shiftWidth-1:0]  shiftAmount;
        logic                   divStart;
        logic                   divDone;
        logic [dataWidth-1:0]   quotient;
        logic [dataWidth-1:0]   remainder;

        assign shiftAmount = busData[shiftWidth-1:0];

        // single-word results leave the high half zero.
        always_comb begin
                opResult = '0;
                case (op)
                        opAdd: opResult[dataWidth-1:0] = yValue + busData;
                        opSub: opResult[dataWidth-1:0] = yValue - busData;
                        opAnd: opResult[dataWidth-1:0] = yValue & busData;
                        opOr:  opResult[dataWidth-1:0] = yValue | busData;
                        opShr: opResult[dataWidth-1:0] = yValue >> shiftAmount;
                        opShl: opResult[dataWidth-1:0] = yValue << shiftAmount;
                        opNeg: opResult[dataWidth-1:0] = -busData;
                        opNot: opResult[dataWidth-1:0] = ~busData;
                        opMul: opResult = {{dataWidth{1'b0}}, yValue} *
                                          {{dataWidth{1'b0}}, busData};
                        default: opResult = '0;
                endcase
        end

        // z loads are dropped while a divide runs.
        assign divStart = zLoad && (op == opDiv) && !busy;
        assign zWrite   = (zLoad && (op != opDiv) && !busy) || divDone;
        assign zResult  = divDone ? {remainder, quotient} : opResult;

        divider divider_inst (
                .Clock     (Clock),
                .rstN      (rstN),
                .start     (divStart),
                .dividend  (yValue),
                .divisor   (busData),
                .busy      (busy),
                .done      (divDone),
                .quotient  (quotient),
                .remainder (remainder)
        );

endmodule

/* source/datapath.sv */
`timescale 1ns/1ns

module datapath import datapathPkg::*; (
        input  logic                    Clock,
        input  logic                    rstN,
        input  busSourcesT              sources,
        input  loadEnablesT             loads,
        input  aluOpT                   op,
        input  logic                    incPc,
        input  logic                    read,
        input  logic [dataWidth-1:0]    memData,
        output logic [dataWidth-1:0]    busData,
        output logic [dataWidth-1:0]    marValue,
        output logic                    busy
);

        sourceCodeT             sourceCode;
        logic [dataWidth-1:0]   regValue;
        logic [dataWidth-1:0]   mdrValue;
        logic [dataWidth-1:0]   pcValue;
        logic [dataWidth-1:0]   yValue;
        logic [dataWidth-1:0]   hiValue;
        logic [dataWidth-1:0]   loValue;
        logic [dataWidth-1:0]   zHighValue;
        logic [dataWidth-1:0]   zLowValue;
        logic [dataWidth-1:0]   cValue;
        logic [2*dataWidth-1:0] zResult;
        logic                   zWrite;

        busEncoder busEncoder_inst (
                .sources    (sources),
                .regValue   (regValue),
                .mdrValue   (mdrValue),
                .hiValue    (hiValue),
                .loValue    (loValue),
                .zHighValue (zHighValue),
                .zLowValue  (zLowValue),
                .pcValue    (pcValue),
                .cValue     (cValue),
                .sourceCode (sourceCode),
                .busData    (busData)
        );

        registerFile registerFile_inst (
                .Clock      (Clock),
                .rstN       (rstN),
                .loads      (loads.gpr),
                .sourceCode (sourceCode),
                .busData    (busData),
                .regValue   (regValue)
        );

        memoryDataRegister memoryDataRegister_inst (
                .Clock    (Clock),
                .rstN     (rstN),
                .mdrLoad  (loads.mdr),
                .marLoad  (loads.mar),
                .read     (read),
                .memData  (memData),
                .busData  (busData),
                .mdrValue (mdrValue),
                .marValue (marValue)
        );

        // IR reaches the bus only through its C field.
        specialRegisters specialRegisters_inst (
                .Clock      (Clock),
                .rstN       (rstN),
                .loads      (loads),
                .incPc      (incPc),
                .busData    (busData),
                .zResult    (zResult),
                .zWrite     (zWrite),
                .pcValue    (pcValue),
                .irValue    (),
                .yValue     (yValue),
                .hiValue    (hiValue),
                .loValue    (loValue),
                .zHighValue (zHighValue),
                .zLowValue  (zLowValue),
                .cValue     (cValue)
        );

        alu alu_inst (
                .Clock   (Clock),
                .rstN    (rstN),
                .op      (op),
                .zLoad   (loads.z),
                .yValue  (yValue),
                .busData (busData),
                .zResult (zResult),
                .zWrite  (zWrite),
                .busy    (busy)
        );

endmodule

/* sim/datapathSteps.svh */
`ifndef DATAPATH_STEPS_SVH
`define DATAPATH_STEPS_SVH

function automatic busSourcesT gprSource(input int index);
        busSourcesT s;
        s = '0;
        s.gpr[index] = 1'b1;
        return s;
endfunction

function automatic loadEnablesT gprLoad(input int index);
        loadEnablesT l;
        l = '0;
        l.gpr[index] = 1'b1;
        return l;
endfunction

// one control step, strobes held until the next one.
task automatic driveStep(input busSourcesT stepSources, input loadEnablesT stepLoads,
                         input aluOpT stepOp, input logic stepInc, input logic stepRead,
                         input logic [dataWidth-1:0] stepMem);
        @(posedge Clock);
        #driveDelay;
        sources = stepSources;
        loads = stepLoads;
        op = stepOp;
        incPc = stepInc;
        read = stepRead;
        memData = stepMem;
        #settleDelay;
endtask

task automatic idleStep();
        driveStep('0, '0, opAdd, 1'b0, 1'b0, '0);
endtask

// memory word into MDR, then MDR onto the bus into the target.
task automatic loadFromMemory(input loadEnablesT target, input logic [dataWidth-1:0] value);
        busSourcesT mdrSource;
        loadEnablesT mdrLoad;
        mdrSource = '0;
        mdrSource.mdr = 1'b1;
        mdrLoad = '0;
        mdrLoad.mdr = 1'b1;
        driveStep('0, mdrLoad, opAdd, 1'b0, 1'b1, value);
        driveStep(mdrSource, target, opAdd, 1'b0, 1'b0, '0);
endtask

task automatic readBus(input string testName, input busSourcesT source,
                       input logic [dataWidth-1:0] expected);
        driveStep(source, '0, opAdd, 1'b0, 1'b0, '0);
        checkValue(testName, expected, busData);
endtask

// Y from one register, then the other on the bus with a z load.
task automatic runOperation(input aluOpT aluOp, input int yIndex, input int busIndex);
        loadEnablesT yLoad;
        loadEnablesT zLoad;
        yLoad = '0;
        yLoad.y = 1'b1;
        zLoad = '0;
        zLoad.z = 1'b1;
        driveStep(gprSource(yIndex), yLoad, opAdd, 1'b0, 1'b0, '0);
        driveStep(gprSource(busIndex), zLoad, aluOp, 1'b0, 1'b0, '0);
endtask

`endif

/* sim/datapathTb.sv */
`timescale 1ns/1ns

module datapathTb import datapathPkg::*; ();

        localparam int clockPeriod = 10;
        localparam int resetCycles = 16;
        localparam int driveDelay = 2;
        localparam int settleDelay = 1;
        localparam int loadRounds = 12;
        localparam int opRounds = 24;
        localparam int divRounds = 6;
        localparam int plannedSteps = resetCycles + 2 * $bits(busSourcesT) + loadRounds * 3 +
                                      opRounds * 8 + divRounds * (8 + divideSteps) + 40;
        localparam int watchdogCycles = plannedSteps * 40;

        logic                   Clock = 1'b0;
        logic                   rstN;
        busSourcesT             sources;
        loadEnablesT            loads;
        aluOpT                  op;
        logic                   incPc;
        logic                   read;
        logic [dataWidth-1:0]   memData;
        logic [dataWidth-1:0]   busData;
        logic [dataWidth-1:0]   marValue;
        logic                   busy;

        logic [31:0]            lcgState = 32'h618e;
        logic [dataWidth-1:0]   regModel [regCount];
        logic [dataWidth-1:0]   hiModel;
        logic [dataWidth-1:0]   loModel;
        logic [dataWidth-1:0]   zHighModel;
        logic [dataWidth-1:0]   zLowModel;
        logic [dataWidth-1:0]   pcModel;
        aluOpT                  opList [9] = '{opAdd, opSub, opAnd, opOr, opShr, opShl,
                                               opNeg, opNot, opMul};

        always #(clockPeriod / 2) Clock = ~Clock;

        datapath datapath_inst (
                .Clock    (Clock),
                .rstN     (rstN),
                .sources  (sources),
                .loads    (loads),
                .op       (op),
                .incPc    (incPc),
                .read     (read),
                .memData  (memData),
                .busData  (busData),
                .marValue (marValue),
                .busy     (busy)
        );

        function automatic logic [31:0] nextRandom();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState;
        endfunction

        // reference results for the single-cycle operations.
        function automatic logic [63:0] expectedResult(input aluOpT aluOp,
                                                       input logic [31:0] a, input logic [31:0] b);
                case (aluOp)
                        opAdd: return {32'd0, a + b};
                        opSub: return {32'd0, a - b};
                        opAnd: return {32'd0, a & b};
                        opOr:  return {32'd0, a | b};
                        opShr: return {32'd0, a >> b[4:0]};
                        opShl: return {32'd0, a << b[4:0]};
                        opNeg: return {32'd0, -b};
                        opNot: return {32'd0, ~b};
                        opMul: return {32'd0, a} * {32'd0, b};
                        default: return '0;
                endcase
        endfunction

        task automatic checkValue(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
                assert (actual === expected)
                else begin
                        $display("mismatch in %s: expected %h, actual %h",
                                 testName, expected, actual);
                        $display("ERRORS FOUND");
                        $fatal(1);
                end
        endtask

        `include "datapathSteps.svh"

        initial begin
                #(watchdogCycles * clockPeriod);
                $display("timeout: run did not finish within %0d cycles", watchdogCycles);
                $display("ERRORS FOUND");
                $fatal(1);
        end

        initial begin
                int                   idx;
                int                   yIdx;
                int                   bIdx;
                int                   count;
                logic [31:0]          value;
                logic [31:0]          divisor;
                logic [63:0]          result;
                busSourcesT           src;
                loadEnablesT          ld;
                aluOpT                aluOp;

                rstN = 1'b0;
                sources = '0;
                loads = '0;
                op = opAdd;
                incPc = 1'b0;
                read = 1'b0;
                memData = '0;
                for (int i = 0; i < regCount; i++)
                        regModel[i] = '0;
                repeat (resetCycles) @(posedge Clock);
                #driveDelay rstN = 1'b1;

                // every source reads zero out of reset.
                for (int i = 0; i < $bits(busSourcesT); i++)
                        readBus($sformatf("reset source %0d", i), busSourcesT'(1 << i), '0);
                readBus("no source", '0, '0);
                checkValue("busy after reset", 32'd0, {31'd0, busy});

                for (int i = 0; i < loadRounds; i++) begin
                        idx = nextRandom() >> 28;
                        value = nextRandom();
                        loadFromMemory(gprLoad(idx), value);
                        regModel[idx] = value;
                end
                hiModel = nextRandom();
                ld = '0;
                ld.hi = 1'b1;
                loadFromMemory(ld, hiModel);
                loModel = nextRandom();
                ld = '0;
                ld.lo = 1'b1;
                loadFromMemory(ld, loModel);
                for (int i = 0; i < regCount; i++)
                        readBus($sformatf("register R%0d", i), gprSource(i), regModel[i]);
                src = '0;
                src.hi = 1'b1;
                readBus("hi readback", src, hiModel);
                src = '0;
                src.lo = 1'b1;
                readBus("lo readback", src, loModel);
                idx = nextRandom() >> 28;
                ld = '0;
                ld.mar = 1'b1;
                driveStep(gprSource(idx), ld, opAdd, 1'b0, 1'b0, '0);
                idleStep();
                checkValue("mar load", regModel[idx], marValue);

                // every operation comes round, the operands stay random.
                for (int i = 0; i < opRounds; i++) begin
                        aluOp = opList[i % 9];
                        yIdx = nextRandom() >> 28;
                        bIdx = nextRandom() >> 28;
                        regModel[yIdx] = nextRandom();
                        loadFromMemory(gprLoad(yIdx), regModel[yIdx]);
                        regModel[bIdx] = nextRandom();
                        loadFromMemory(gprLoad(bIdx), regModel[bIdx]);
                        runOperation(aluOp, yIdx, bIdx);
                        result = expectedResult(aluOp, regModel[yIdx], regModel[bIdx]);
                        zHighModel = result[63:32];
                        zLowModel = result[31:0];
                        // zLow travels through LO before the read.
                        src = '0;
                        src.zLow = 1'b1;
                        ld = '0;
                        ld.lo = 1'b1;
                        driveStep(src, ld, opAdd, 1'b0, 1'b0, '0);
                        src = '0;
                        src.lo = 1'b1;
                        readBus($sformatf("%s low via lo", aluOp.name()), src, zLowModel);
                        src = '0;
                        src.zHigh = 1'b1;
                        readBus($sformatf("%s high", aluOp.name()), src, zHighModel);
                end

                for (int i = 0; i < divRounds; i++) begin
                        yIdx = nextRandom() >> 28;
                        bIdx = (yIdx + 1) % regCount;
                        value = nextRandom();
                        divisor = (i == 0) ? '0 : nextRandom() >> (nextRandom() >> 27);
                        loadFromMemory(gprLoad(yIdx), value);
                        loadFromMemory(gprLoad(bIdx), divisor);
                        regModel[yIdx] = value;
                        regModel[bIdx] = divisor;
                        runOperation(opDiv, yIdx, bIdx);
                        // this z load lands while busy and must be dropped.
                        ld = '0;
                        ld.z = 1'b1;
                        driveStep(gprSource(bIdx), ld, opAdd, 1'b0, 1'b0, '0);
                        count = 0;
                        src = '0;
                        src.zLow = 1'b1;
                        while (busy) begin
                                count++;
                                driveStep(src, '0, opAdd, 1'b0, 1'b0, '0);
                                if (busy)
                                        checkValue("z held during divide", zLowModel, busData);
                        end
                        checkValue("divide busy cycles", divideSteps, count);
                        if (divisor == 0) begin
                                zLowModel = '1;
                                zHighModel = value;
                        end else begin
                                zLowModel = value / divisor;
                                zHighModel = value % divisor;
                        end
                        readBus("divide quotient", src, zLowModel);
                        src = '0;
                        src.zHigh = 1'b1;
                        readBus("divide remainder", src, zHighModel);
                end

                pcModel = nextRandom();
                ld = '0;
                ld.pc = 1'b1;
                loadFromMemory(ld, pcModel);
                count = 1 + (nextRandom() >> 29);
                for (int i = 0; i < count; i++)
                        driveStep('0, '0, opAdd, 1'b1, 1'b0, '0);
                pcModel = pcModel + count;
                src = '0;
                src.pc = 1'b1;
                readBus("pc increment", src, pcModel);
                idx = nextRandom() >> 28;
                driveStep(gprSource(idx), ld, opAdd, 1'b0, 1'b0, '0);
                readBus("pc load after count", src, regModel[idx]);

                // low 19 bits moved to the top, then shifted back arithmetically.
                for (int i = 0; i < 4; i++) begin
                        value = nextRandom();
                        ld = '0;
                        ld.ir = 1'b1;
                        loadFromMemory(ld, value);
                        src = '0;
                        src.c = 1'b1;
                        readBus("c field", src,
                                $signed(value << (dataWidth - immediateWidth)) >>>
                                (dataWidth - immediateWidth));
                end

                idleStep();
                $display("NO ERRORS");
                $finish;
        end

endmodule

/* vlog.f */
+incdir+sim
source/datapathPkg.sv
source/busEncoder.sv
source/registerFile.sv
source/memoryDataRegister.sv
source/specialRegisters.sv
source/divider.sv
source/alu.sv
source/datapath.sv
sim/datapathTb.sv
